// File: filelist.f
hdl/i2c_sender_pkg.sv
hdl/sysbus_if.sv
hdl/system_bus_controller.sv
hdl/sender_script_rom.sv
hdl/i2c_send_sequencer.sv
hdl/i2c_sender.sv
tests/i2c_sender_assertions.sv
tests/i2c_sender_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --assert --top-module i2c_sender_tb -f filelist.f -o i2c_sender_sim || exit 1
out="$(./obj_dir/i2c_sender_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tests/i2c_sender_tb.sv
`timescale 1ns/1ps

module i2c_sender_tb
    import i2c_sender_pkg::*;
();
    localparam int RUN_TIMEOUT  = 5000;
    localparam int QUIET_CYCLES = 20;

    logic      clock;
    logic      reset;
    bus_data_t sbdat_from_peripheral;
    logic      sback;
    logic      sbclk;
    logic      sbrw;
    logic      sbstb;
    bus_addr_t sbadr;
    bus_data_t sbdat_to_peripheral;
    logic      finished;
    logic      fault;

    integer    seed;
    int        value_errors;
    int        other_errors;
    int        ack_delay;
    int        idle_busy_polls;
    int        stop_count;
    int        txdr_in_xfer;
    logic      nack_run;
    logic      in_xfer;
    logic      idle_polled;
    logic      last_idle_busy;
    bus_addr_t exp_addr [$];
    bus_data_t exp_data [$];

    i2c_sender dut (
        .clock                 (clock),
        .reset                 (reset),
        .sbdat_from_peripheral (sbdat_from_peripheral),
        .sback                 (sback),
        .sbclk                 (sbclk),
        .sbrw                  (sbrw),
        .sbstb                 (sbstb),
        .sbadr                 (sbadr),
        .sbdat_to_peripheral   (sbdat_to_peripheral),
        .finished              (finished),
        .fault                 (fault)
    );

    always #50 clock = ~clock;

    // the bus clock follows clock, looked at halfway through each phase
    always @(clock) begin
        #25;
        assert (sbclk == clock) else begin
            value_errors++;
            $display("FAILED %0t sbclk got %b expected %b", $time, sbclk, clock);
        end
    end

    function automatic bus_data_t expected_byte(input int xfer, input int index);
        if (index == 0) begin
            return 8'h46;
        end else if (index == 1) begin
            return bus_data_t'(xfer);
        end
        return bus_data_t'(xfer * xfer);
    endfunction

    task automatic queue_write(input bus_addr_t addr, input bus_data_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // register writes in the order the vendor flow issues them
    task automatic build_expected(input logic with_nack);
        for (int s = 0; s < NUM_SETUP_REGS; s++) begin
            queue_write({I2C_BASE, SETUP_OFFSETS[s]}, SETUP_VALUES[s]);
        end
        for (int x = 0; x < NUM_XFERS; x++) begin
            for (int b = 0; b < XFER_BYTES; b++) begin
                queue_write({I2C_BASE, TXDR_OFFSET}, expected_byte(x, b));
                queue_write({I2C_BASE, CMDR_OFFSET}, (b == 0) ? 8'h94 : 8'h14);
                // the nack lands on the address byte of transfer 1
                if (with_nack && x == 1) begin
                    queue_write({I2C_BASE, CMDR_OFFSET}, 8'h44);
                    return;
                end
            end
            queue_write({I2C_BASE, CMDR_OFFSET}, 8'h44);
        end
    endtask

    task automatic track_write();
        if (sbadr == {I2C_BASE, TXDR_OFFSET}) begin
            if (!in_xfer) begin
                assert (idle_polled && !last_idle_busy) else begin
                    other_errors++;
                    $display("TXDR written at %0t before the status showed the bus idle", $time);
                end
            end
            txdr_in_xfer++;
        end else if (sbadr == {I2C_BASE, CMDR_OFFSET}) begin
            if (sbdat_to_peripheral == 8'h44) begin
                in_xfer         = 1'b0;
                txdr_in_xfer    = 0;
                idle_polled     = 1'b0;
                stop_count++;
                idle_busy_polls = 1 + $unsigned($random(seed)) % 3;
            end else begin
                in_xfer = 1'b1;
            end
        end
    endtask

    task automatic check_write();
        bus_addr_t want_addr;
        bus_data_t want_data;
        assert (exp_addr.size() != 0) else begin
            other_errors++;
            $display("unexpected write of %h to address %h at %0t",
                     sbdat_to_peripheral, sbadr, $time);
        end
        if (exp_addr.size() != 0) begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            assert (sbadr == want_addr) else begin
                value_errors++;
                $display("FAILED %0t sbadr got %h expected %h", $time, sbadr, want_addr);
            end
            assert (sbdat_to_peripheral == want_data) else begin
                value_errors++;
                $display("FAILED %0t sbdat_to_peripheral got %h expected %h",
                         $time, sbdat_to_peripheral, want_data);
            end
        end
        track_write();
    endtask

    task automatic answer_status(output bus_data_t value);
        assert (sbadr == {I2C_BASE, SR_OFFSET}) else begin
            other_errors++;
            $display("read from address %h at %0t, only the status register is read",
                     sbadr, $time);
        end
        if (in_xfer) begin
            if (nack_run && stop_count == 1 && txdr_in_xfer == 1) begin
                value = 8'h42;
            end else begin
                value = 8'h44;
            end
        end else begin
            idle_polled = 1'b1;
            if (idle_busy_polls > 0) begin
                idle_busy_polls--;
                last_idle_busy = 1'b1;
                value          = 8'h40;
            end else begin
                last_idle_busy = 1'b0;
                value          = 8'h00;
            end
        end
    endtask

    // i2c block register model with a random acknowledge delay
    always @(posedge clock) begin
        bus_data_t status;
        if (!reset) begin
            sback <= 1'b0;
        end else if (sbstb && !sback) begin
            if (ack_delay > 0) begin
                ack_delay--;
            end else begin
                sback     <= 1'b1;
                ack_delay = $unsigned($random(seed)) % 4;
                if (sbrw) begin
                    check_write();
                end else begin
                    answer_status(status);
                    sbdat_from_peripheral <= status;
                end
            end
        end else begin
            sback <= 1'b0;
        end
    end

    task automatic run_sequence(input logic with_nack);
        int cycles;
        @(posedge clock);
        reset <= 1'b0;
        nack_run        = with_nack;
        in_xfer         = 1'b0;
        idle_polled     = 1'b0;
        last_idle_busy  = 1'b0;
        stop_count      = 0;
        txdr_in_xfer    = 0;
        ack_delay       = 0;
        idle_busy_polls = 1 + $unsigned($random(seed)) % 3;
        exp_addr.delete();
        exp_data.delete();
        build_expected(with_nack);
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        cycles = 0;
        @(negedge clock);
        while (!finished && !fault && cycles < RUN_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (finished || fault) else begin
            other_errors++;
            $display("timeout, neither finished nor fault rose within %0d cycles", RUN_TIMEOUT);
        end
        assert (finished == !with_nack && fault == with_nack) else begin
            other_errors++;
            $display("wrong ending at %0t, finished %b fault %b", $time, finished, fault);
        end
        assert (exp_addr.size() == 0) else begin
            other_errors++;
            $display("%0d expected writes never appeared", exp_addr.size());
        end
        assert (stop_count == (with_nack ? 2 : NUM_XFERS)) else begin
            other_errors++;
            $display("saw %0d stop commands", stop_count);
        end
        // the bus has to stay quiet once the sequence has ended
        for (int q = 0; q < QUIET_CYCLES; q++) begin
            @(negedge clock);
            assert (!sbstb && finished == !with_nack && fault == with_nack) else begin
                other_errors++;
                $display("bus activity or status change at %0t after the end", $time);
            end
        end
    endtask

    initial begin
        seed                  = 88386;
        clock                 = 1'b0;
        reset                 = 1'b0;
        sback                 = 1'b0;
        sbdat_from_peripheral = '0;
        value_errors          = 0;
        other_errors          = 0;
        run_sequence(1'b0);
        run_sequence(1'b1);
        $display("errors: %0d wrong value, %0d other, %0d bus assertion",
                 value_errors, other_errors, dut.u_controller.bus_checks.failures);
        if (value_errors + other_errors + dut.u_controller.bus_checks.failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/i2c_sender_assertions.sv
`timescale 1ns/1ps

module i2c_sender_assertions
    import i2c_sender_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      sbstb,
    input logic      sbrw,
    input bus_addr_t sbadr,
    input bus_data_t sbdat_to_peripheral,
    input logic      sback
);
    int failures = 0;

    // a strobe waiting for its acknowledge stays up
    property strobe_held;
        @(posedge clock) disable iff (!reset)
        (sbstb && !sback) |=> sbstb;
    endproperty

    property fields_stable;
        @(posedge clock) disable iff (!reset)
        (sbstb && !sback) |=> ($stable(sbadr) && $stable(sbrw) && $stable(sbdat_to_peripheral));
    endproperty

    // one acknowledge ends the access
    property strobe_ends;
        @(posedge clock) disable iff (!reset)
        (sbstb && sback) |=> !sbstb;
    endproperty

    property quiet_in_reset;
        @(posedge clock) !reset |=> !sbstb;
    endproperty

    assert property (strobe_held) else begin
        failures++;
        $error("sbstb dropped before sback");
    end

    assert property (fields_stable) else begin
        failures++;
        $error("address, direction or write data moved while waiting for sback");
    end

    assert property (strobe_ends) else begin
        failures++;
        $error("sbstb still high after the acknowledged cycle");
    end

    assert property (quiet_in_reset) else begin
        failures++;
        $error("sbstb high during reset");
    end

endmodule

bind system_bus_controller i2c_sender_assertions bus_checks (
    .clock               (clock),
    .reset               (reset),
    .sbstb               (sbstb),
    .sbrw                (sbrw),
    .sbadr               (sbadr),
    .sbdat_to_peripheral (sbdat_to_peripheral),
    .sback               (sback)
);

// File: hdl/i2c_sender.sv
`timescale 1ns/1ps

module i2c_sender
    import i2c_sender_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  bus_data_t sbdat_from_peripheral,
    input  logic      sback,
    output logic      sbclk,
    output logic      sbrw,
    output logic      sbstb,
    output bus_addr_t sbadr,
    output bus_data_t sbdat_to_peripheral,
    output logic      finished,
    output logic      fault
);
    sysbus_if bus ();

    setup_index_t setup_index;
    xfer_index_t  xfer_index;
    byte_index_t  byte_index;
    bus_addr_t    setup_addr;
    bus_data_t    setup_data;
    bus_data_t    xfer_byte;

    system_bus_controller u_controller (
        .clock                 (clock),
        .reset                 (reset),
        .bus                   (bus.controller),
        .sbclk                 (sbclk),
        .sbrw                  (sbrw),
        .sbstb                 (sbstb),
        .sbadr                 (sbadr),
        .sbdat_to_peripheral   (sbdat_to_peripheral),
        .sbdat_from_peripheral (sbdat_from_peripheral),
        .sback                 (sback)
    );

    sender_script_rom u_script (
        .setup_index (setup_index),
        .xfer_index  (xfer_index),
        .byte_index  (byte_index),
        .setup_addr  (setup_addr),
        .setup_data  (setup_data),
        .xfer_byte   (xfer_byte)
    );

    i2c_send_sequencer u_sequencer (
        .clock       (clock),
        .reset       (reset),
        .bus         (bus.requester),
        .setup_index (setup_index),
        .xfer_index  (xfer_index),
        .byte_index  (byte_index),
        .setup_addr  (setup_addr),
        .setup_data  (setup_data),
        .xfer_byte   (xfer_byte),
        .finished    (finished),
        .fault       (fault)
    );

endmodule

// File: hdl/i2c_send_sequencer.sv
`timescale 1ns/1ps

module i2c_send_sequencer
    import i2c_sender_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    sysbus_if.requester  bus,
    output setup_index_t setup_index,
    output xfer_index_t  xfer_index,
    output byte_index_t  byte_index,
    input  bus_addr_t    setup_addr,
    input  bus_data_t    setup_data,
    input  bus_data_t    xfer_byte,
    output logic         finished,
    output logic         fault
);
    sender_state_t state;

    logic sr_busy;
    logic sr_trrdy;
    logic sr_nack;
    logic last_setup;
    logic last_byte;
    logic last_xfer;

    // status bits are only looked at in the done cycle of an SR read
    assign sr_busy  = (bus.read_data & SR_BUSY_MASK) != '0;
    assign sr_trrdy = (bus.read_data & SR_TRRDY_MASK) != '0;
    assign sr_nack  = (bus.read_data & SR_NACK_MASK) != '0;

    assign last_setup = (setup_index == setup_index_t'(NUM_SETUP_REGS - 1));
    assign last_byte  = (byte_index == byte_index_t'(XFER_BYTES - 1));
    assign last_xfer  = (xfer_index == xfer_index_t'(NUM_XFERS - 1));

    assign finished = (state == i2c_sender_pkg::finished);
    assign fault    = (state == i2c_sender_pkg::fault);

    // request fields follow the state and stay stable until done
    always_comb begin
        bus.addr       = {I2C_BASE, SR_OFFSET};
        bus.write_data = '0;
        bus.read_write = 1'b0;
        bus.start      = 1'b1;
        case (state)
            setup_write: begin
                bus.addr       = setup_addr;
                bus.write_data = setup_data;
                bus.read_write = 1'b1;
            end
            wait_idle, wait_trrdy: begin
                bus.addr = {I2C_BASE, SR_OFFSET};
            end
            write_txdr: begin
                bus.addr       = {I2C_BASE, TXDR_OFFSET};
                bus.write_data = xfer_byte;
                bus.read_write = 1'b1;
            end
            write_cmdr: begin
                bus.addr       = {I2C_BASE, CMDR_OFFSET};
                bus.write_data = (byte_index == '0) ? CMD_START_WRITE : CMD_WRITE;
                bus.read_write = 1'b1;
            end
            write_stop, nack_stop: begin
                bus.addr       = {I2C_BASE, CMDR_OFFSET};
                bus.write_data = CMD_STOP;
                bus.read_write = 1'b1;
            end
            default: begin
                // finished or fault, the bus goes quiet
                bus.start = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= setup_write;
            setup_index <= '0;
            xfer_index  <= '0;
            byte_index  <= '0;
        end else if (bus.done) begin
            case (state)
                setup_write: begin
                    if (last_setup) begin
                        state <= wait_idle;
                    end else begin
                        setup_index <= setup_index + 1'b1;
                    end
                end
                wait_idle: begin
                    // keep polling SR until the i2c bus is free
                    if (!sr_busy) begin
                        state <= write_txdr;
                    end
                end
                write_txdr: begin
                    state <= write_cmdr;
                end
                write_cmdr: begin
                    state <= wait_trrdy;
                end
                wait_trrdy: begin
                    if (sr_nack) begin
                        state <= nack_stop;
                    end else if (sr_trrdy) begin
                        if (last_byte) begin
                            byte_index <= '0;
                            state      <= write_stop;
                        end else begin
                            byte_index <= byte_index + 1'b1;
                            state      <= write_txdr;
                        end
                    end else if (!sr_busy) begin
                        // bus dropped busy without taking the byte
                        state <= i2c_sender_pkg::fault;
                    end
                end
                write_stop: begin
                    if (last_xfer) begin
                        state <= i2c_sender_pkg::finished;
                    end else begin
                        xfer_index <= xfer_index + 1'b1;
                        state      <= wait_idle;
                    end
                end
                nack_stop: begin
                    state <= i2c_sender_pkg::fault;
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

endmodule

// File: hdl/sender_script_rom.sv
`timescale 1ns/1ps

module sender_script_rom
    import i2c_sender_pkg::*;
(
    input  setup_index_t setup_index,
    input  xfer_index_t  xfer_index,
    input  byte_index_t  byte_index,
    output bus_addr_t    setup_addr,
    output bus_data_t    setup_data,
    output bus_data_t    xfer_byte
);
    bus_data_t xfer_value;
    bus_data_t xfer_square;

    // setup entries, all in the i2c block's address window
    assign setup_addr = {I2C_BASE, SETUP_OFFSETS[setup_index]};
    assign setup_data = SETUP_VALUES[setup_index];

    assign xfer_value  = bus_data_t'(xfer_index);
    assign xfer_square = xfer_value * xfer_value;

    // transfer i carries 0x46, i, i*i
    always_comb begin
        case (byte_index)
            2'd0: begin
                xfer_byte = FIRST_XFER_BYTE;
            end
            2'd1: begin
                xfer_byte = xfer_value;
            end
            2'd2: begin
                xfer_byte = xfer_square;
            end
            default: begin
                xfer_byte = '0;
            end
        endcase
    end

endmodule

// File: hdl/system_bus_controller.sv
`timescale 1ns/1ps

module system_bus_controller
    import i2c_sender_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    sysbus_if.controller bus,
    output logic         sbclk,
    output logic         sbrw,
    output logic         sbstb,
    output bus_addr_t    sbadr,
    output bus_data_t    sbdat_to_peripheral,
    input  bus_data_t    sbdat_from_peripheral,
    input  logic         sback
);
    typedef enum logic {
        idle,
        strobe
    } bus_state_t;

    bus_state_t state;
    logic       done_pulse;
    logic       accept;
    logic       ack_seen;
    bus_data_t  read_capture;

    assign sbclk = clock;
    assign sbstb = (state == strobe);

    assign bus.done      = done_pulse;
    assign bus.read_data = read_capture;

    // the request is still held during its own done cycle, so that one is skipped
    assign accept   = (state == idle) && bus.start && !done_pulse;
    assign ack_seen = (state == strobe) && sback;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= idle;
            done_pulse <= 1'b0;
        end else begin
            done_pulse <= 1'b0;
            case (state)
                idle: begin
                    if (accept) begin
                        state <= strobe;
                    end
                end
                strobe: begin
                    // strobe holds until the peripheral acknowledges
                    if (sback) begin
                        state      <= idle;
                        done_pulse <= 1'b1;
                    end
                end
            endcase
        end
    end

    // address, direction and write byte are latched once per request
    always_ff @(posedge clock) begin
        if (accept) begin
            sbrw                <= bus.read_write;
            sbadr               <= bus.addr;
            sbdat_to_peripheral <= bus.write_data;
        end
    end

    // read byte is valid in the done cycle
    always_ff @(posedge clock) begin
        if (ack_seen && !sbrw) begin
            read_capture <= sbdat_from_peripheral;
        end
    end

endmodule

// File: hdl/sysbus_if.sv
`timescale 1ns/1ps

interface sysbus_if
    import i2c_sender_pkg::*;
();
    bus_addr_t addr;
    bus_data_t write_data;
    logic      read_write;  // 1 is a write
    logic      start;
    logic      done;
    bus_data_t read_data;

    // request fields stay put until done is seen
    modport requester (
        output addr,
        output write_data,
        output read_write,
        output start,
        input  done,
        input  read_data
    );

    modport controller (
        input  addr,
        input  write_data,
        input  read_write,
        input  start,
        output done,
        output read_data
    );
endinterface

// File: hdl/i2c_sender_pkg.sv
package i2c_sender_pkg;

    typedef logic [7:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;
    typedef logic [3:0] reg_offset_t;
    typedef logic [1:0] setup_index_t;
    typedef logic [1:0] xfer_index_t;
    typedef logic [1:0] byte_index_t;

    typedef enum logic [3:0] {
        setup_write,
        wait_idle,
        write_txdr,
        write_cmdr,
        wait_trrdy,
        write_stop,
        nack_stop,
        finished,
        fault
    } sender_state_t;

    // upper address nibble of the hardened i2c block
    localparam logic [3:0] I2C_BASE = 4'b0001;

    localparam reg_offset_t CR1_OFFSET   = 4'b0001;
    localparam reg_offset_t BRLSB_OFFSET = 4'b0010;
    localparam reg_offset_t BRMSB_OFFSET = 4'b0011;
    localparam reg_offset_t IRQEN_OFFSET = 4'b0101;
    localparam reg_offset_t CMDR_OFFSET  = 4'b0111;
    localparam reg_offset_t TXDR_OFFSET  = 4'b1000;
    localparam reg_offset_t SR_OFFSET    = 4'b1011;

    localparam bus_data_t SR_BUSY_MASK  = 8'b0100_0000;
    localparam bus_data_t SR_TRRDY_MASK = 8'b0000_0100;
    localparam bus_data_t SR_NACK_MASK  = 8'b0000_0010;

    localparam bus_data_t CMD_START_WRITE = 8'h94;
    localparam bus_data_t CMD_WRITE       = 8'h14;
    localparam bus_data_t CMD_STOP        = 8'h44;

    localparam int NUM_SETUP_REGS = 4;
    localparam int NUM_XFERS      = 4;
    localparam int XFER_BYTES     = 3;

    localparam bus_data_t FIRST_XFER_BYTE = 8'h46;

    // setup table, written in this order after reset
    localparam reg_offset_t SETUP_OFFSETS [NUM_SETUP_REGS] =
        '{CR1_OFFSET, BRLSB_OFFSET, BRMSB_OFFSET, IRQEN_OFFSET};
    localparam bus_data_t SETUP_VALUES [NUM_SETUP_REGS] =
        '{8'h80, 8'd120, 8'h00, 8'h06};

endpackage
